/* design/ddr3_seq_defines.svh */
`ifndef DDR3_SEQ_DEFINES_SVH
`define DDR3_SEQ_DEFINES_SVH

// ----------------------------------------
// Clock and PHY latencies
// ----------------------------------------
`define DDR_MHZ             50
`define DDR_CYCLE_NS        (1000 / `DDR_MHZ)
`define DDR_WRITE_LATENCY   6
`define DDR_READ_LATENCY    5
`define DDR_PHY_WRLAT       (`DDR_WRITE_LATENCY - 1)
`define DDR_PHY_RDLAT       (`DDR_READ_LATENCY - 1)
`define DDR_BURST_LEN       4

// ----------------------------------------
// Widths
// ----------------------------------------
`define DDR_ROW_W           15
`define DDR_BANK_W          3
`define DDR_DATA_W          32
`define DDR_DQM_W           4
`define DDR_LINE_W          (`DDR_DATA_W * `DDR_BURST_LEN)
`define DDR_LINE_MASK_W     (`DDR_DQM_W * `DDR_BURST_LEN)

// ----------------------------------------
// Command spacing in clock cycles
// ----------------------------------------
// Nanosecond limits rounded up to whole cycles
`define DDR_TRCD_CYCLES     ((15 + `DDR_CYCLE_NS - 1) / `DDR_CYCLE_NS)
`define DDR_TRP_CYCLES      ((15 + `DDR_CYCLE_NS - 1) / `DDR_CYCLE_NS)
`define DDR_TRFC_CYCLES     ((260 + `DDR_CYCLE_NS - 1) / `DDR_CYCLE_NS)
`define DDR_TWTR_CYCLES     6
// Read/write to any following command
`define DDR_RW_CYCLES       (`DDR_WRITE_LATENCY + `DDR_BURST_LEN + `DDR_TWTR_CYCLES)
`define DDR_DELAY_W         6
`define DDR_WR_FIFO_DEPTH   4

`endif

/* design/ddr3_seq_pkg.sv */
`include "ddr3_seq_defines.svh"

package ddr3_seq_pkg;

    // Command code on {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0]
    {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_ZQCL      = 4'b0110,
        CMD_NOP       = 4'b0111
    } ddr_cmd_t;

    // One write line, mask above data
    typedef struct packed
    {
        logic [`DDR_LINE_MASK_W-1:0] mask;
        logic [`DDR_LINE_W-1:0]      data;
    } ddr_wr_line_t;

endpackage

/* design/ddr3_cmd_timer.sv */
`timescale 1ns/1ps
`include "ddr3_seq_defines.svh"

module ddr3_cmd_timer
    import ddr3_seq_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  ddr_cmd_t command_i,
    output logic     accept_o,
    output logic     wr_fire_o,
    output logic     rd_fire_o
);

    localparam int DELAY_W = `DDR_DELAY_W;

    logic [DELAY_W-1:0] delay_q;
    logic [DELAY_W-1:0] delay_d;

    // ----------------------------------------
    // Spacing counter
    // ----------------------------------------
    always_comb
    begin
        delay_d = delay_q;
        if (delay_q == '0)
        begin
            // Idle, so the command is taken now
            case (command_i)
                CMD_ACTIVE:    delay_d = DELAY_W'(`DDR_TRCD_CYCLES);
                CMD_PRECHARGE: delay_d = DELAY_W'(`DDR_TRP_CYCLES);
                CMD_REFRESH:   delay_d = DELAY_W'(`DDR_TRFC_CYCLES);
                CMD_READ,
                CMD_WRITE:     delay_d = DELAY_W'(`DDR_RW_CYCLES);
                // LOAD_MODE, ZQCL and NOP need no gap
                default:       delay_d = '0;
            endcase
        end
        else
        begin
            delay_d = delay_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            delay_q <= '0;
        end
        else
        begin
            delay_q <= delay_d;
        end
    end

    // ----------------------------------------
    // Handshake and strobes
    // ----------------------------------------
    // NOP never waits
    assign accept_o  = (delay_q == '0) || (command_i == CMD_NOP);

    // Accepted bursts start the data paths
    assign wr_fire_o = accept_o && (command_i == CMD_WRITE);
    assign rd_fire_o = accept_o && (command_i == CMD_READ);

endmodule

/* design/ddr3_cmd_issue.sv */
`timescale 1ns/1ps
`include "ddr3_seq_defines.svh"

module ddr3_cmd_issue
    import ddr3_seq_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   accept_i,
    input  ddr_cmd_t               command_i,
    input  logic [`DDR_ROW_W-1:0]  address_i,
    input  logic [`DDR_BANK_W-1:0] bank_i,
    input  logic                   cke_i,
    output logic [`DDR_ROW_W-1:0]  dfi_address_o,
    output logic [`DDR_BANK_W-1:0] dfi_bank_o,
    output logic                   dfi_cs_n_o,
    output logic                   dfi_ras_n_o,
    output logic                   dfi_cas_n_o,
    output logic                   dfi_we_n_o,
    output logic                   dfi_cke_o
);

    ddr_cmd_t command_q;

    // One cycle on the pins per accepted command
    always_ff @(posedge clk_i)
    begin
        if (rst_i || !accept_i)
        begin
            command_q     <= CMD_NOP;
            dfi_address_o <= '0;
            dfi_bank_o    <= '0;
        end
        else
        begin
            command_q     <= command_i;
            dfi_address_o <= address_i;
            dfi_bank_o    <= bank_i;
        end
    end

    // CKE is not tied to the handshake
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            dfi_cke_o <= 1'b0;
        end
        else
        begin
            dfi_cke_o <= cke_i;
        end
    end

    // Split code onto the control pins
    assign {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} = command_q;

endmodule

/* design/ddr3_wr_fifo.sv */
`timescale 1ns/1ps
`include "ddr3_seq_defines.svh"

module ddr3_wr_fifo
    import ddr3_seq_pkg::*;
#(
    parameter int DEPTH = `DDR_WR_FIFO_DEPTH
)
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         push_i,
    input  ddr_wr_line_t data_i,
    input  logic         pop_i,
    output ddr_wr_line_t data_o
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int CNT_W  = ADDR_W + 1;

    ddr_wr_line_t      mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr_q;
    logic [ADDR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              push_ok;
    logic              pop_ok;

    // Guard against stray strobes at the edges
    assign push_ok = push_i && (count_q != CNT_W'(DEPTH));
    assign pop_ok  = pop_i && (count_q != '0);

    // Storage
    always_ff @(posedge clk_i)
    begin
        if (push_ok)
        begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    // Pointers wrap at the power-of-two depth
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            wr_ptr_q <= wr_ptr_q + ADDR_W'(push_ok);
            rd_ptr_q <= rd_ptr_q + ADDR_W'(pop_ok);
            count_q  <= count_q + CNT_W'(push_ok) - CNT_W'(pop_ok);
        end
    end

    // Oldest line always visible
    assign data_o = mem[rd_ptr_q];

endmodule

/* design/ddr3_wr_path.sv */
`timescale 1ns/1ps
`include "ddr3_seq_defines.svh"

module ddr3_wr_path
    import ddr3_seq_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        wr_fire_i,
    input  logic [`DDR_LINE_W-1:0]      wrdata_i,
    input  logic [`DDR_LINE_MASK_W-1:0] wrdata_mask_i,
    output logic [`DDR_DATA_W-1:0]      dfi_wrdata_o,
    output logic [`DDR_DQM_W-1:0]       dfi_wrdata_mask_o,
    output logic                        dfi_wrdata_en_o
);

    localparam int WRLAT      = `DDR_PHY_WRLAT;
    localparam int BURST      = `DDR_BURST_LEN;
    localparam int WR_SHIFT_W = WRLAT + BURST;

    ddr_wr_line_t          push_line;
    ddr_wr_line_t          head_line;
    logic [WR_SHIFT_W-1:0] wr_en_q;
    logic                  beat_en;
    logic [1:0]            beat_idx_q;
    logic                  pop;

    // ----------------------------------------
    // Line buffer
    // ----------------------------------------
    assign push_line = '{mask: wrdata_mask_i, data: wrdata_i};

    ddr3_wr_fifo #(
        .DEPTH  (`DDR_WR_FIFO_DEPTH)
    ) u_fifo (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .push_i (wr_fire_i),
        .data_i (push_line),
        .pop_i  (pop),
        .data_o (head_line)
    );

    // ----------------------------------------
    // Beat enable
    // ----------------------------------------
    // Four ones enter at the top, bit 0 rises WRLAT edges later
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_en_q <= '0;
        end
        else if (wr_fire_i)
        begin
            wr_en_q <= {{BURST{1'b1}}, wr_en_q[WRLAT:1]};
        end
        else
        begin
            wr_en_q <= {1'b0, wr_en_q[WR_SHIFT_W-1:1]};
        end
    end

    assign beat_en = wr_en_q[0];
    // Line done after its top word
    assign pop     = beat_en && (beat_idx_q == 2'd3);

    // ----------------------------------------
    // Serializer
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            dfi_wrdata_o      <= '0;
            dfi_wrdata_mask_o <= '0;
            dfi_wrdata_en_o   <= 1'b0;
            beat_idx_q        <= '0;
        end
        else
        begin
            dfi_wrdata_en_o <= beat_en;
            if (beat_en)
            begin
                // Lowest word first
                dfi_wrdata_o      <= head_line.data[beat_idx_q * `DDR_DATA_W +: `DDR_DATA_W];
                dfi_wrdata_mask_o <= head_line.mask[beat_idx_q * `DDR_DQM_W +: `DDR_DQM_W];
                beat_idx_q        <= beat_idx_q + 2'd1;
            end
            else
            begin
                // Quiet bus between bursts
                dfi_wrdata_o      <= '0;
                dfi_wrdata_mask_o <= '0;
            end
        end
    end

endmodule

/* design/ddr3_rd_path.sv */
`timescale 1ns/1ps
`include "ddr3_seq_defines.svh"

module ddr3_rd_path
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   rd_fire_i,
    input  logic [`DDR_DATA_W-1:0] dfi_rddata_i,
    input  logic                   dfi_rddata_valid_i,
    output logic                   dfi_rddata_en_o,
    output logic [`DDR_LINE_W-1:0] rddata_o,
    output logic                   rddata_valid_o
);

    localparam int RDLAT      = `DDR_PHY_RDLAT;
    localparam int BURST      = `DDR_BURST_LEN;
    localparam int RD_SHIFT_W = RDLAT + BURST;

    logic [RD_SHIFT_W-1:0] rd_en_q;
    logic [1:0]            beat_idx_q;

    // ----------------------------------------
    // Read enable
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rd_en_q         <= '0;
            dfi_rddata_en_o <= 1'b0;
        end
        else
        begin
            if (rd_fire_i)
            begin
                rd_en_q <= {{BURST{1'b1}}, rd_en_q[RDLAT:1]};
            end
            else
            begin
                rd_en_q <= {1'b0, rd_en_q[RD_SHIFT_W-1:1]};
            end
            // Extra flop keeps the PHY pin registered
            dfi_rddata_en_o <= rd_en_q[0];
        end
    end

    // ----------------------------------------
    // Beat gatherer
    // ----------------------------------------
    // New beats enter at the top, so the first ends lowest
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rddata_o       <= '0;
            rddata_valid_o <= 1'b0;
            beat_idx_q     <= '0;
        end
        else
        begin
            rddata_valid_o <= dfi_rddata_valid_i && (beat_idx_q == 2'd3);
            if (dfi_rddata_valid_i)
            begin
                rddata_o   <= {dfi_rddata_i, rddata_o[`DDR_LINE_W-1:`DDR_DATA_W]};
                beat_idx_q <= beat_idx_q + 2'd1;
            end
        end
    end

endmodule

/* design/ddr3_dfi_seq.sv */
`timescale 1ns/1ps
`include "ddr3_seq_defines.svh"

module ddr3_dfi_seq
    import ddr3_seq_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    // Requester side
    input  ddr_cmd_t                    command_i,
    input  logic [`DDR_ROW_W-1:0]       address_i,
    input  logic [`DDR_BANK_W-1:0]      bank_i,
    input  logic                        cke_i,
    input  logic [`DDR_LINE_W-1:0]      wrdata_i,
    input  logic [`DDR_LINE_MASK_W-1:0] wrdata_mask_i,
    output logic                        accept_o,
    output logic [`DDR_LINE_W-1:0]      rddata_o,
    output logic                        rddata_valid_o,
    // PHY side
    output logic [`DDR_ROW_W-1:0]       dfi_address_o,
    output logic [`DDR_BANK_W-1:0]      dfi_bank_o,
    output logic                        dfi_cs_n_o,
    output logic                        dfi_ras_n_o,
    output logic                        dfi_cas_n_o,
    output logic                        dfi_we_n_o,
    output logic                        dfi_cke_o,
    output logic [`DDR_DATA_W-1:0]      dfi_wrdata_o,
    output logic [`DDR_DQM_W-1:0]       dfi_wrdata_mask_o,
    output logic                        dfi_wrdata_en_o,
    output logic                        dfi_rddata_en_o,
    input  logic [`DDR_DATA_W-1:0]      dfi_rddata_i,
    input  logic                        dfi_rddata_valid_i
);

    logic wr_fire;
    logic rd_fire;

    // Spacing and strobes
    ddr3_cmd_timer u_timer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .command_i (command_i),
        .accept_o  (accept_o),
        .wr_fire_o (wr_fire),
        .rd_fire_o (rd_fire)
    );

    // Command pins
    ddr3_cmd_issue u_issue (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .accept_i      (accept_o),
        .command_i     (command_i),
        .address_i     (address_i),
        .bank_i        (bank_i),
        .cke_i         (cke_i),
        .dfi_address_o (dfi_address_o),
        .dfi_bank_o    (dfi_bank_o),
        .dfi_cs_n_o    (dfi_cs_n_o),
        .dfi_ras_n_o   (dfi_ras_n_o),
        .dfi_cas_n_o   (dfi_cas_n_o),
        .dfi_we_n_o    (dfi_we_n_o),
        .dfi_cke_o     (dfi_cke_o)
    );

    // Write data
    ddr3_wr_path u_wr (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .wr_fire_i         (wr_fire),
        .wrdata_i          (wrdata_i),
        .wrdata_mask_i     (wrdata_mask_i),
        .dfi_wrdata_o      (dfi_wrdata_o),
        .dfi_wrdata_mask_o (dfi_wrdata_mask_o),
        .dfi_wrdata_en_o   (dfi_wrdata_en_o)
    );

    // Read data
    ddr3_rd_path u_rd (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .rd_fire_i          (rd_fire),
        .dfi_rddata_i       (dfi_rddata_i),
        .dfi_rddata_valid_i (dfi_rddata_valid_i),
        .dfi_rddata_en_o    (dfi_rddata_en_o),
        .rddata_o           (rddata_o),
        .rddata_valid_o     (rddata_valid_o)
    );

endmodule

/* testbench/ddr3_seq_checker.sv */
`timescale 1ns/1ps
`include "ddr3_seq_defines.svh"

module ddr3_seq_checker
    import ddr3_seq_pkg::*;
(
    input logic                        clk_i,
    input logic                        rst_i,
    input ddr_cmd_t                    command_i,
    input logic [`DDR_ROW_W-1:0]       address_i,
    input logic [`DDR_BANK_W-1:0]      bank_i,
    input logic                        cke_i,
    input logic [`DDR_LINE_W-1:0]      wrdata_i,
    input logic [`DDR_LINE_MASK_W-1:0] wrdata_mask_i,
    input logic                        accept_o,
    input logic [`DDR_LINE_W-1:0]      rddata_o,
    input logic                        rddata_valid_o,
    input logic [`DDR_ROW_W-1:0]       dfi_address_o,
    input logic [`DDR_BANK_W-1:0]      dfi_bank_o,
    input logic                        dfi_cs_n_o,
    input logic                        dfi_ras_n_o,
    input logic                        dfi_cas_n_o,
    input logic                        dfi_we_n_o,
    input logic                        dfi_cke_o,
    input logic [`DDR_DATA_W-1:0]      dfi_wrdata_o,
    input logic [`DDR_DQM_W-1:0]       dfi_wrdata_mask_o,
    input logic                        dfi_wrdata_en_o,
    input logic                        dfi_rddata_en_o,
    input logic                        dfi_rddata_valid_i
);

    localparam int DELAY_W = `DDR_DELAY_W;

    int                 fail_count;
    logic               rst_d_q;
    logic [DELAY_W-1:0] gap_q;
    logic [9:0]         wr_hist_q;
    logic [9:0]         rd_hist_q;
    ddr_wr_line_t       lines [16];
    logic [3:0]         head_q;
    logic [3:0]         tail_q;
    logic [1:0]         wr_beat_q;
    logic [1:0]         rd_beat_q;
    ddr_wr_line_t       exp_line;
    logic               wr_take;
    logic               rd_take;
    logic [3:0]         pins;

    assign wr_take  = accept_o && (command_i == CMD_WRITE);
    assign rd_take  = accept_o && (command_i == CMD_READ);
    assign pins     = {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o};
    // Line whose beats are due next
    assign exp_line = lines[tail_q];

    // Gap after each command in clock cycles
    function automatic logic [DELAY_W-1:0] spacing(input ddr_cmd_t cmd);
        case (cmd)
            CMD_ACTIVE:    return DELAY_W'(1);
            CMD_PRECHARGE: return DELAY_W'(1);
            CMD_REFRESH:   return DELAY_W'(13);
            CMD_READ,
            CMD_WRITE:     return DELAY_W'(16);
            default:       return '0;
        endcase
    endfunction

    task automatic record_failure(input string what);
        $error("%s", what);
        fail_count++;
    endtask

    // ----------------------------------------
    // Reference state
    // ----------------------------------------
    always_ff @(posedge clk_i)
    begin
        rst_d_q <= rst_i;
        if (rst_i)
        begin
            gap_q     <= '0;
            wr_hist_q <= '0;
            rd_hist_q <= '0;
            head_q    <= '0;
            tail_q    <= '0;
            wr_beat_q <= '0;
            rd_beat_q <= '0;
        end
        else
        begin
            if (accept_o && (command_i != CMD_NOP))
                gap_q <= spacing(command_i);
            else if (gap_q != '0)
                gap_q <= gap_q - 1'b1;
            // Bit k set means a burst was taken k+1 edges ago
            wr_hist_q <= {wr_hist_q[8:0], wr_take};
            rd_hist_q <= {rd_hist_q[8:0], rd_take};
            if (wr_take)
                head_q <= head_q + 4'd1;
            if (dfi_wrdata_en_o)
            begin
                wr_beat_q <= wr_beat_q + 2'd1;
                if (wr_beat_q == 2'd3)
                    tail_q <= tail_q + 4'd1;
            end
            if (dfi_rddata_valid_i)
                rd_beat_q <= rd_beat_q + 2'd1;
        end
    end

    // Written lines in accept order
    always_ff @(posedge clk_i)
    begin
        if (wr_take)
            lines[head_q] <= {wrdata_mask_i, wrdata_i};
    end

    // ----------------------------------------
    // Properties
    // ----------------------------------------
    a_accept: assert property (@(posedge clk_i) disable iff (rst_i)
        accept_o == ((gap_q == '0) || (command_i == CMD_NOP)))
        else record_failure("accept_o does not follow the command spacing");

    a_issue: assert property (@(posedge clk_i) disable iff (rst_i)
        !rst_d_q && $past(accept_o) |-> (pins == $past(command_i))
        && (dfi_address_o == $past(address_i)) && (dfi_bank_o == $past(bank_i)))
        else record_failure("DFI pins do not show the accepted command");

    a_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        !rst_d_q && !$past(accept_o) |-> (pins == CMD_NOP)
        && (dfi_address_o == '0) && (dfi_bank_o == '0))
        else record_failure("DFI pins not idle without an accepted command");

    a_cke: assert property (@(posedge clk_i) disable iff (rst_i)
        !rst_d_q |-> dfi_cke_o == $past(cke_i))
        else record_failure("dfi_cke_o does not follow cke_i by one cycle");

    // Enable seen at sample k+1 for a burst taken k edges back
    a_wr_en: assert property (@(posedge clk_i) disable iff (rst_i)
        dfi_wrdata_en_o == (|wr_hist_q[9:6]))
        else record_failure("dfi_wrdata_en_o window is wrong");

    a_wr_data: assert property (@(posedge clk_i) disable iff (rst_i)
        dfi_wrdata_en_o |->
        (dfi_wrdata_o == exp_line.data[wr_beat_q * `DDR_DATA_W +: `DDR_DATA_W])
        && (dfi_wrdata_mask_o == exp_line.mask[wr_beat_q * `DDR_DQM_W +: `DDR_DQM_W]))
        else record_failure("write beat or mask differs from the written line");

    a_wr_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        !dfi_wrdata_en_o |-> (dfi_wrdata_o == '0) && (dfi_wrdata_mask_o == '0))
        else record_failure("write data not zero outside a burst");

    a_rd_en: assert property (@(posedge clk_i) disable iff (rst_i)
        dfi_rddata_en_o == (|rd_hist_q[8:5]))
        else record_failure("dfi_rddata_en_o window is wrong");

    a_rd_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        rddata_valid_o == $past(dfi_rddata_valid_i && (rd_beat_q == 2'd3)))
        else record_failure("rddata_valid_o not one cycle after the fourth beat");

    // Outputs right after a reset edge
    a_reset: assert property (@(posedge clk_i)
        rst_d_q |-> accept_o && (pins == CMD_NOP) && !dfi_cke_o && !dfi_wrdata_en_o
        && !dfi_rddata_en_o && !rddata_valid_o && (rddata_o == '0)
        && (dfi_wrdata_o == '0) && (dfi_wrdata_mask_o == '0))
        else record_failure("outputs not at reset values");

endmodule

bind ddr3_dfi_seq ddr3_seq_checker u_chk (.*);

/* testbench/ddr3_seq_tb.sv */
`timescale 1ns/1ps
`include "ddr3_seq_defines.svh"

module ddr3_seq_tb
    import ddr3_seq_pkg::*;
();

    localparam int WAIT_LIMIT = 64;
    localparam int MIX_COUNT  = 40;
    localparam int ROW_W      = `DDR_ROW_W;
    localparam int BANK_W     = `DDR_BANK_W;
    localparam int MASK_W     = `DDR_LINE_MASK_W;
    localparam int DATA_W     = `DDR_DATA_W;

    logic                        clk_i;
    logic                        rst_i;
    ddr_cmd_t                    command_i;
    logic [`DDR_ROW_W-1:0]       address_i;
    logic [`DDR_BANK_W-1:0]      bank_i;
    logic                        cke_i;
    logic [`DDR_LINE_W-1:0]      wrdata_i;
    logic [`DDR_LINE_MASK_W-1:0] wrdata_mask_i;
    logic                        accept_o;
    logic [`DDR_LINE_W-1:0]      rddata_o;
    logic                        rddata_valid_o;
    logic [`DDR_ROW_W-1:0]       dfi_address_o;
    logic [`DDR_BANK_W-1:0]      dfi_bank_o;
    logic                        dfi_cs_n_o;
    logic                        dfi_ras_n_o;
    logic                        dfi_cas_n_o;
    logic                        dfi_we_n_o;
    logic                        dfi_cke_o;
    logic [`DDR_DATA_W-1:0]      dfi_wrdata_o;
    logic [`DDR_DQM_W-1:0]       dfi_wrdata_mask_o;
    logic                        dfi_wrdata_en_o;
    logic                        dfi_rddata_en_o;
    logic [`DDR_DATA_W-1:0]      dfi_rddata_i;
    logic                        dfi_rddata_valid_i;
    // Beats handed back by the PHY model, oldest first
    logic [`DDR_DATA_W-1:0]      beat_q [$];
    int                          reads_issued;
    int                          lines_checked;
    int unsigned                 seed_sink;

    ddr3_dfi_seq dut0 (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .command_i          (command_i),
        .address_i          (address_i),
        .bank_i             (bank_i),
        .cke_i              (cke_i),
        .wrdata_i           (wrdata_i),
        .wrdata_mask_i      (wrdata_mask_i),
        .accept_o           (accept_o),
        .rddata_o           (rddata_o),
        .rddata_valid_o     (rddata_valid_o),
        .dfi_address_o      (dfi_address_o),
        .dfi_bank_o         (dfi_bank_o),
        .dfi_cs_n_o         (dfi_cs_n_o),
        .dfi_ras_n_o        (dfi_ras_n_o),
        .dfi_cas_n_o        (dfi_cas_n_o),
        .dfi_we_n_o         (dfi_we_n_o),
        .dfi_cke_o          (dfi_cke_o),
        .dfi_wrdata_o       (dfi_wrdata_o),
        .dfi_wrdata_mask_o  (dfi_wrdata_mask_o),
        .dfi_wrdata_en_o    (dfi_wrdata_en_o),
        .dfi_rddata_en_o    (dfi_rddata_en_o),
        .dfi_rddata_i       (dfi_rddata_i),
        .dfi_rddata_valid_i (dfi_rddata_valid_i)
    );

    // 8 ns clock
    initial
    begin
        clk_i = 1'b0;
        forever
        begin
            #4 clk_i = ~clk_i;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    // Hold one command until a rising edge takes it
    task automatic send_command(input ddr_cmd_t cmd);
        int waited;
        waited        = 0;
        command_i     = cmd;
        address_i     = (cmd == CMD_NOP) ? '0 : ROW_W'($urandom());
        bank_i        = (cmd == CMD_NOP) ? '0 : BANK_W'($urandom());
        wrdata_i      = {$urandom(), $urandom(), $urandom(), $urandom()};
        wrdata_mask_i = MASK_W'($urandom());
        // Accept settles on the new command
        #1;
        while (!accept_o)
        begin
            @(posedge clk_i);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                fail_run("timeout waiting for accept_o to rise");
        end
        @(posedge clk_i);
        #1;
        if (cmd == CMD_READ)
            reads_issued++;
        command_i = CMD_NOP;
        address_i = '0;
        bank_i    = '0;
    endtask

    // ----------------------------------------
    // PHY model and read line compare
    // ----------------------------------------
    initial
    begin : phy_model
        logic [2:0]             en_hist;
        logic [`DDR_DATA_W-1:0] beat;
        logic [`DDR_LINE_W-1:0] line;
        en_hist = '0;
        forever
        begin
            @(posedge clk_i);
            #1;
            if (dut0.u_chk.fail_count != 0)
                fail_run("a bound assertion reported an error");
            if (rddata_valid_o)
            begin
                if (beat_q.size() < `DDR_BURST_LEN)
                    fail_run("rddata_valid_o pulsed before four beats came back");
                // First returned beat sits in the lowest word
                line = '0;
                for (int k = 0; k < `DDR_BURST_LEN; k++)
                begin
                    beat = beat_q.pop_front();
                    line[k * DATA_W +: DATA_W] = beat;
                end
                if (rddata_o !== line)
                    fail_run($sformatf("CHECK FAILED rddata_o got %h expected %h",
                                       rddata_o, line));
                lines_checked++;
            end
            // Beat returns two cycles after its enable
            en_hist = {en_hist[1:0], dfi_rddata_en_o};
            dfi_rddata_valid_i = en_hist[2];
            if (en_hist[2])
            begin
                beat         = $urandom();
                dfi_rddata_i = beat;
                beat_q.push_back(beat);
            end
            else
            begin
                dfi_rddata_i = '0;
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial
    begin : stimulus
        logic [3:0] pick;
        int         waited;
        seed_sink          = $urandom(32'hbf75_bd3a);
        rst_i              = 1'b1;
        command_i          = CMD_NOP;
        address_i          = '0;
        bank_i             = '0;
        cke_i              = 1'b0;
        wrdata_i           = '0;
        wrdata_mask_i      = '0;
        dfi_rddata_i       = '0;
        dfi_rddata_valid_i = 1'b0;
        reads_issued       = 0;
        lines_checked      = 0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        cke_i = 1'b1;

        // Directed sequence
        send_command(CMD_ACTIVE);
        send_command(CMD_WRITE);
        send_command(CMD_WRITE);
        send_command(CMD_READ);
        send_command(CMD_PRECHARGE);
        send_command(CMD_REFRESH);
        send_command(CMD_LOAD_MODE);

        // Random mix, NOP and CKE changes included
        for (int i = 0; i < MIX_COUNT; i++)
        begin
            pick  = 4'($urandom_range(7, 0));
            cke_i = ($urandom_range(3, 0) != 0);
            send_command(ddr_cmd_t'(pick));
        end

        // Taken only once the last burst gap is over
        cke_i = 1'b1;
        send_command(CMD_ZQCL);
        waited = 0;
        while (lines_checked != reads_issued)
        begin
            @(posedge clk_i);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                fail_run("timeout waiting for outstanding read lines");
        end

        if (dut0.u_chk.fail_count != 0)
        begin
            fail_run("a bound assertion reported an error");
        end
        else
        begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+design
design/ddr3_seq_pkg.sv
design/ddr3_cmd_timer.sv
design/ddr3_cmd_issue.sv
design/ddr3_wr_fifo.sv
design/ddr3_wr_path.sv
design/ddr3_rd_path.sv
design/ddr3_dfi_seq.sv
testbench/ddr3_seq_checker.sv
testbench/ddr3_seq_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the DDR3 sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module ddr3_seq_tb -f compile.f \
    -o ddr3_seq_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/ddr3_seq_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log && exit 0 || exit 1
